//--- design/sig_ctrl_pkg.sv
`default_nettype none

package sig_ctrl_pkg;

    // ======================================================================
    // Operation and divider sequencing
    // ======================================================================

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } sig_op_e;

    typedef enum logic [2:0] {
        DS_IDLE    = 3'd0,
        DS_SEED    = 3'd1,
        DS_ITER_D  = 3'd2,
        DS_ITER_N  = 3'd3,
        DS_BACKMUL = 3'd4,
        DS_CORRECT = 3'd5
    } div_state_e;

    // Goldschmidt passes after the 8-bit seed
    localparam logic [1:0] ITER_DBL = 2'd3;
    localparam logic [1:0] ITER_SGL = 2'd2;

    // Issue to mul_done
    localparam int MUL_LAT = 2;

endpackage

`default_nettype wire

//--- design/sig_fmt_pkg.sv
`default_nettype none

package sig_fmt_pkg;

    import sig_ctrl_pkg::*;

    // ======================================================================
    // Significand widths
    // ======================================================================

    localparam int SIG_W = 53;
    localparam int RES_W = 57;
    localparam int FQ_W  = RES_W - 1;
    localparam int EXT_W = 58;

    // Single precision keeps the top 27 result bits
    localparam int SGL_DROP = 29;
    localparam logic [FQ_W-1:0] SGL_MASK = {{(FQ_W-SGL_DROP){1'b1}}, {SGL_DROP{1'b0}}};

    // Divider fixed point, two integer bits
    localparam int SEED_W = 8;
    localparam int DIV_W  = 64;
    localparam int DIV_F  = 62;
    localparam logic [DIV_W-1:0] DIV_TWO = {1'b1, {(DIV_W-1){1'b0}}};

    // Signed remainder of fa*2^55 - q*fb
    localparam int REM_W = SIG_W + FQ_W + 2;

    // ======================================================================
    // Request and result
    // ======================================================================

    typedef struct packed {
        sig_op_e          op;
        logic             db;
        logic [SIG_W-1:0] fa;
        logic [SIG_W-1:0] fb;
    } sig_req_t;

    typedef struct packed {
        sig_op_e         op;
        logic            db;
        logic [FQ_W-1:0] fq;
        logic            sticky;
    } sig_res_t;

endpackage

`default_nettype wire

//--- design/recip_rom.sv
`timescale 1ns/1ps
`default_nettype none

module recip_rom (
    input  logic [sig_fmt_pkg::SEED_W-1:0] addr,
    output logic [sig_fmt_pkg::SEED_W-1:0] seed
);

    import sig_fmt_pkg::*;

    logic [SEED_W-1:0] rom_q [1 << SEED_W];

    // Fraction bits below the leading 0.1 of 1/(1.idx), truncated
    function automatic logic [SEED_W-1:0] seed_entry(input int idx);
        int recip;
        recip = (1 << (2 * SEED_W + 1)) / ((1 << SEED_W) + idx);
        recip = recip - (1 << SEED_W);
        // idx 0 gives exactly 1.0
        if (recip > (1 << SEED_W) - 1) begin
            recip = (1 << SEED_W) - 1;
        end
        return SEED_W'(recip);
    endfunction

    for (genvar i = 0; i < (1 << SEED_W); i++) begin : g_fill
        assign rom_q[i] = seed_entry(i);
    end

    assign seed = rom_q[addr];

endmodule

`default_nettype wire

//--- design/sig_mul_path.sv
`timescale 1ns/1ps
`default_nettype none

module sig_mul_path (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  sig_fmt_pkg::sig_req_t req,
    output logic                  mul_done,
    output sig_fmt_pkg::sig_res_t mul_res
);

    import sig_fmt_pkg::*;
    import sig_ctrl_pkg::*;

    logic               v1;
    logic               db1;
    logic [EXT_W-1:0]   a1;
    logic [EXT_W-1:0]   b1;
    logic [2*EXT_W-1:0] prod;

    assign prod = a1 * b1;

    // ======================================================================
    // Stage valid bits
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1       <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            v1       <= issue;
            mul_done <= v1;
        end
    end

    // Stage 1 operands, stage 2 product top and sticky
    always_ff @(posedge clk) begin
        a1  <= EXT_W'(req.fa) << (EXT_W - SIG_W);
        b1  <= EXT_W'(req.fb) << (EXT_W - SIG_W);
        db1 <= req.db;

        mul_res <= '{op:     OP_MUL,
                     db:     db1,
                     fq:     prod[2*EXT_W-1 -: FQ_W],
                     sticky: |prod[2*EXT_W-FQ_W-1:0]};
    end

    a_mul_lat : assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> ##MUL_LAT mul_done);

endmodule

`default_nettype wire

//--- design/sig_div_path.sv
`timescale 1ns/1ps
`default_nettype none

module sig_div_path (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  sig_fmt_pkg::sig_req_t req,
    output logic                  busy,
    output logic                  div_done,
    output sig_fmt_pkg::sig_res_t div_res
);

    import sig_fmt_pkg::*;
    import sig_ctrl_pkg::*;

    div_state_e              state;
    logic [1:0]              ph;
    logic [1:0]              iter_cnt;
    logic                    db_r;
    logic [SIG_W-1:0]        fa_r;
    logic [SIG_W-1:0]        fb_r;
    logic [SEED_W-1:0]       seed;
    logic [DIV_W-1:0]        fa_ext;
    logic [DIV_W-1:0]        fb_ext;
    logic [DIV_W-1:0]        seed_ext;
    logic [DIV_W-1:0]        mul_a;
    logic [DIV_W-1:0]        mul_b;
    logic [2*DIV_W-1:0]      prod;
    logic [DIV_W-1:0]        prod_t;
    logic [DIV_W-1:0]        d_q;
    logic [DIV_W-1:0]        n_q;
    logic [FQ_W-1:0]         q_raw;
    logic [FQ_W-1:0]         q_t;
    logic [FQ_W-1:0]         step;
    logic [FQ_W-1:0]         q_fix;
    logic [REM_W-1:0]        num_ext;
    logic [REM_W-1:0]        bprod_ext;
    logic signed [REM_W-1:0] diff;
    logic signed [REM_W-1:0] unit_s;
    logic signed [REM_W-1:0] rem_fix;

    recip_rom u_rom (
        .addr (fb_r[SIG_W-2 -: SEED_W]),
        .seed (seed)
    );

    assign busy = (state != DS_IDLE);

    // Operands aligned so the hidden one lands on the unit bit
    assign fa_ext   = DIV_W'(fa_r) << (DIV_F - SIG_W + 1);
    assign fb_ext   = DIV_W'(fb_r) << (DIV_F - SIG_W + 1);
    assign seed_ext = DIV_W'({1'b1, seed}) << (DIV_F - SEED_W - 1);

    // Shared multiplier, truncated back to the working format
    assign prod   = mul_a * mul_b;
    assign prod_t = prod[DIV_F +: DIV_W];

    // Quotient estimate; n_q at or above 2 saturates
    assign q_raw = n_q[DIV_W-1] ? '1 : n_q[DIV_F -: FQ_W];
    assign q_t   = db_r ? q_raw : (q_raw & SGL_MASK);

    assign num_ext   = REM_W'({fa_r, {(FQ_W-1){1'b0}}});
    assign bprod_ext = REM_W'(prod[SIG_W+FQ_W-1:0]);

    // One quotient unit, scaled up in single precision
    assign step   = FQ_W'(1) << (db_r ? 0 : SGL_DROP);
    assign unit_s = REM_W'(fb_r) << (db_r ? 0 : SGL_DROP);

    always_comb begin
        q_fix   = q_t;
        rem_fix = diff;
        if (diff < 0) begin
            q_fix   = q_t - step;
            rem_fix = diff + unit_s;
        end else if (diff >= unit_s) begin
            q_fix   = q_t + step;
            rem_fix = diff - unit_s;
        end
    end

    // ======================================================================
    // Sequencing
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= DS_IDLE;
            ph       <= '0;
            iter_cnt <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            ph       <= ph + 2'd1;
            case (state)
                DS_IDLE: begin
                    ph <= '0;
                    if (issue) begin
                        state    <= DS_SEED;
                        iter_cnt <= req.db ? ITER_DBL : ITER_SGL;
                    end
                end
                // Four phases, ph wraps back to zero
                DS_SEED: begin
                    if (ph == 2'd3) begin
                        state <= DS_ITER_D;
                    end
                end
                DS_ITER_D: begin
                    if (ph[0]) begin
                        state <= DS_ITER_N;
                        ph    <= '0;
                    end
                end
                DS_ITER_N: begin
                    if (ph[0]) begin
                        ph       <= '0;
                        iter_cnt <= iter_cnt - 2'd1;
                        state    <= (iter_cnt == 2'd1) ? DS_BACKMUL : DS_ITER_D;
                    end
                end
                DS_BACKMUL: begin
                    if (ph[0]) begin
                        state <= DS_CORRECT;
                        ph    <= '0;
                    end
                end
                DS_CORRECT: begin
                    state    <= DS_IDLE;
                    ph       <= '0;
                    div_done <= 1'b1;
                end
                default: begin
                    state <= DS_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Datapath, ph 0 loads the multiplier and ph 1 takes its product
    // ======================================================================

    always_ff @(posedge clk) begin
        case (state)
            DS_IDLE: begin
                if (issue) begin
                    fa_r <= req.fa;
                    fb_r <= req.fb;
                    db_r <= req.db;
                end
            end
            DS_SEED: begin
                case (ph)
                    2'd0: begin
                        mul_a <= seed_ext;
                        mul_b <= fb_ext;
                    end
                    2'd1: d_q <= prod_t;
                    2'd2: mul_b <= fa_ext;
                    default: n_q <= prod_t;
                endcase
            end
            DS_ITER_D: begin
                // mul_a keeps 2 - d for the numerator pass
                if (!ph[0]) begin
                    mul_a <= DIV_TWO - d_q;
                    mul_b <= d_q;
                end else begin
                    d_q <= prod_t;
                end
            end
            DS_ITER_N: begin
                if (!ph[0]) begin
                    mul_b <= n_q;
                end else begin
                    n_q <= prod_t;
                end
            end
            DS_BACKMUL: begin
                if (!ph[0]) begin
                    mul_a <= DIV_W'(q_t);
                    mul_b <= DIV_W'(fb_r);
                end else begin
                    diff <= $signed(num_ext) - $signed(bprod_ext);
                end
            end
            DS_CORRECT: begin
                div_res <= '{op: OP_DIV, db: db_r, fq: q_fix, sticky: (rem_fix != 0)};
            end
            default: begin
            end
        endcase
    end

    a_no_issue_busy : assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !issue);

    // Iteration accuracy keeps the estimate within one unit
    a_one_step : assert property (@(posedge clk) disable iff (!rst_n)
        (state == DS_CORRECT) |-> (diff > -unit_s) && (diff < (unit_s <<< 1)));

endmodule

`default_nettype wire

//--- design/sig_result_fold.sv
`timescale 1ns/1ps
`default_nettype none

module sig_result_fold (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mul_done,
    input  logic                  div_done,
    input  sig_fmt_pkg::sig_res_t mul_res,
    input  sig_fmt_pkg::sig_res_t div_res,
    output logic                  done,
    output sig_fmt_pkg::sig_res_t res
);

    import sig_fmt_pkg::*;

    sig_res_t pick;
    sig_res_t folded;

    // ======================================================================
    // Path select and precision fold
    // ======================================================================

    always_comb begin
        pick   = div_done ? div_res : mul_res;
        folded = pick;
        // Single precision, low bits go to sticky
        if (!pick.db) begin
            folded.fq     = pick.fq & SGL_MASK;
            folded.sticky = pick.sticky | (|(pick.fq & ~SGL_MASK));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= mul_done | div_done;
        end
    end

    always_ff @(posedge clk) begin
        res <= folded;
    end

    // Start gating upstream keeps the paths apart
    a_one_source : assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_done && div_done));

endmodule

`default_nettype wire

//--- design/sig_muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module sig_muldiv_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  sig_fmt_pkg::sig_req_t req,
    output logic                  busy,
    output logic                  done,
    output sig_fmt_pkg::sig_res_t res
);

    import sig_fmt_pkg::*;
    import sig_ctrl_pkg::*;

    logic     mul_issue;
    logic     div_issue;
    logic     mul_done;
    logic     div_done;
    sig_res_t mul_res;
    sig_res_t div_res;

    // Nothing is accepted while a divide runs
    assign mul_issue = start && !busy && (req.op == OP_MUL);
    assign div_issue = start && !busy && (req.op == OP_DIV);

    sig_mul_path u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (mul_issue),
        .req      (req),
        .mul_done (mul_done),
        .mul_res  (mul_res)
    );

    sig_div_path u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (div_issue),
        .req      (req),
        .busy     (busy),
        .div_done (div_done),
        .div_res  (div_res)
    );

    sig_result_fold u_fold (
        .clk      (clk),
        .rst_n    (rst_n),
        .mul_done (mul_done),
        .div_done (div_done),
        .mul_res  (mul_res),
        .div_res  (div_res),
        .done     (done),
        .res      (res)
    );

endmodule

`default_nettype wire

//--- dv/sig_muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sig_muldiv_tb;

    import sig_fmt_pkg::*;
    import sig_ctrl_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * 2000;
    localparam int RES_WAIT    = 200;
    localparam logic [SIG_W-1:0] ONE     = 53'h10000000000000;
    localparam logic [SIG_W-1:0] ONE_P25 = 53'h14000000000000;
    localparam logic [SIG_W-1:0] ONE_P5  = 53'h18000000000000;
    // Exact product with a set bit below the single precision cut
    localparam logic [SIG_W-1:0] ONE_LOWBIT = 53'h10000000001000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    sig_req_t    req;
    logic        busy;
    logic        done;
    sig_res_t    res;
    integer      seed = 32'hfbae3da4;
    int unsigned cyc = 0;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    sig_res_t    res_q[$];
    int unsigned res_cyc_q[$];
    sig_req_t    burst_q[$];

    sig_muldiv_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .res   (res)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Results captured at the falling edge
    always @(negedge clk) begin
        if (done === 1'b1) begin
            res_q.push_back(res);
            res_cyc_q.push_back(cyc);
        end
    end

    // ======================================================================
    // Reference model and helpers
    // ======================================================================

    function automatic sig_res_t model(input sig_req_t r);
        logic [115:0]    p;
        logic [127:0]    num;
        logic [127:0]    den;
        logic [FQ_W-1:0] fq;
        logic [FQ_W-1:0] low;
        logic            st;
        if (r.op == OP_MUL) begin
            p  = ({63'd0, r.fa} << 5) * ({63'd0, r.fb} << 5);
            fq = p[115:60];
            st = |p[59:0];
        end else begin
            num = {75'd0, r.fa} << 55;
            den = {75'd0, r.fb};
            fq  = FQ_W'(num / den);
            st  = (num % den) != 0;
        end
        // Single precision keeps the top bits only
        if (!r.db) begin
            low = fq & ((FQ_W'(1) << SGL_DROP) - FQ_W'(1));
            fq  = fq ^ low;
            st  = st | (low != 0);
        end
        return '{op: r.op, db: r.db, fq: fq, sticky: st};
    endfunction

    function automatic logic [SIG_W-1:0] rand_sig();
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        return {1'b1, raw[SIG_W-2:0]};
    endfunction

    function automatic sig_req_t make_req(input sig_op_e op, input logic db,
                                          input logic [SIG_W-1:0] fa,
                                          input logic [SIG_W-1:0] fb);
        return '{op: op, db: db, fa: fa, fb: fb};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_res(input sig_res_t exp, input sig_res_t got);
        check_val("res.fq", 64'(exp.fq), 64'(got.fq));
        check_val("res.sticky", 64'(exp.sticky), 64'(got.sticky));
        check_val("res.op", 64'(exp.op), 64'(got.op));
        check_val("res.db", 64'(exp.db), 64'(got.db));
        if (!exp.db) begin
            check_val("res.fq low bits", 64'd0, 64'(got.fq[SGL_DROP-1:0]));
        end
    endtask

    task automatic drive_start(input sig_req_t r);
        @(posedge clk);
        #1;
        start = 1'b1;
        req   = r;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_result(output sig_res_t r, output int unsigned c);
        int n;
        n = 0;
        r = '0;
        c = 0;
        while (res_q.size() == 0 && n < RES_WAIT) begin
            @(posedge clk);
            n++;
        end
        assert (res_q.size() != 0) else begin
            $display("No result arrived within %0d cycles at t=%0t", RES_WAIT, $time);
            errors++;
        end
        if (res_q.size() != 0) begin
            r = res_q.pop_front();
            c = res_cyc_q.pop_front();
        end
    endtask

    task automatic run_one(input sig_req_t r);
        sig_res_t    got;
        int unsigned c;
        drive_start(r);
        drive_idle();
        wait_result(got, c);
        check_res(model(r), got);
    endtask

    // Multiplies issued on consecutive cycles
    task automatic run_mul_burst();
        sig_res_t    exp_q[$];
        int unsigned sc_q[$];
        sig_res_t    got;
        int unsigned c;
        int unsigned lat;
        while (burst_q.size() != 0) begin
            exp_q.push_back(model(burst_q[0]));
            drive_start(burst_q.pop_front());
            sc_q.push_back(cyc);
        end
        drive_idle();
        while (exp_q.size() != 0) begin
            wait_result(got, c);
            check_res(exp_q.pop_front(), got);
            lat = c - sc_q.pop_front();
            check_val("done latency", 64'(MUL_LAT + 1), 64'(lat));
        end
    endtask

    task automatic report_test(input string name, input int e0);
        if (errors == e0) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: %0d errors", name, errors - e0);
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (12) begin
            @(posedge clk);
            #1;
            // Release after the eighth edge
            if (cyc == 8) begin
                rst_n = 1'b1;
            end
            check_val("done", 64'd0, 64'(done));
            check_val("busy", 64'd0, 64'(busy));
        end
        check_val("result count", 64'd0, 64'(res_q.size()));
        report_test("reset", e0);
    endtask

    task automatic test_mul_dbl();
        int e0;
        e0 = errors;
        burst_q.push_back(make_req(OP_MUL, 1'b1, ONE, ONE));
        burst_q.push_back(make_req(OP_MUL, 1'b1, '1, '1));
        burst_q.push_back(make_req(OP_MUL, 1'b1, ONE_P5, ONE_P25));
        repeat (10) burst_q.push_back(make_req(OP_MUL, 1'b1, rand_sig(), rand_sig()));
        run_mul_burst();
        report_test("mul_double", e0);
    endtask

    task automatic test_div_dbl();
        int e0;
        e0 = errors;
        run_one(make_req(OP_DIV, 1'b1, ONE, ONE));
        run_one(make_req(OP_DIV, 1'b1, 53'h1abcdef0123456, 53'h1abcdef0123456));
        run_one(make_req(OP_DIV, 1'b1, ONE_P5, ONE));
        run_one(make_req(OP_DIV, 1'b1, '1, ONE));
        run_one(make_req(OP_DIV, 1'b1, ONE, ONE_P5));
        run_one(make_req(OP_DIV, 1'b1, ONE, '1));
        repeat (6) run_one(make_req(OP_DIV, 1'b1, rand_sig(), rand_sig()));
        report_test("div_double", e0);
    endtask

    task automatic test_single();
        int e0;
        e0 = errors;
        burst_q.push_back(make_req(OP_MUL, 1'b0, ONE_P5, ONE_P25));
        burst_q.push_back(make_req(OP_MUL, 1'b0, ONE_LOWBIT, ONE));
        repeat (4) burst_q.push_back(make_req(OP_MUL, 1'b0, rand_sig(), rand_sig()));
        run_mul_burst();
        run_one(make_req(OP_DIV, 1'b0, ONE, ONE));
        run_one(make_req(OP_DIV, 1'b0, ONE, ONE_P5));
        repeat (3) run_one(make_req(OP_DIV, 1'b0, rand_sig(), rand_sig()));
        report_test("single", e0);
    endtask

    task automatic test_busy_gating();
        sig_req_t    d0;
        sig_res_t    got;
        int unsigned c;
        int          e0;
        e0 = errors;
        d0 = make_req(OP_DIV, 1'b1, rand_sig(), rand_sig());
        drive_start(d0);
        // Both of these land while the divide runs
        drive_start(make_req(OP_MUL, 1'b1, ONE_P5, ONE_P5));
        check_val("busy", 64'd1, 64'(busy));
        drive_start(make_req(OP_DIV, 1'b1, ONE, ONE_P25));
        drive_idle();
        wait_result(got, c);
        check_res(model(d0), got);
        repeat (6) @(posedge clk);
        assert (res_q.size() == 0) else begin
            $display("A request issued while busy produced a result at t=%0t", $time);
            errors++;
        end
        run_one(make_req(OP_MUL, 1'b1, ONE_P5, ONE_P25));
        run_one(make_req(OP_DIV, 1'b0, rand_sig(), rand_sig()));
        report_test("busy_gating", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        test_reset();
        test_mul_dbl();
        test_div_dbl();
        test_single();
        test_busy_gating();
        repeat (4) @(posedge clk);
        $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/sig_ctrl_pkg.sv
design/sig_fmt_pkg.sv
design/recip_rom.sv
design/sig_mul_path.sv
design/sig_div_path.sv
design/sig_result_fold.sv
design/sig_muldiv_top.sv
dv/sig_muldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the significand mul/div testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module sig_muldiv_tb -Mdir obj_dir -o sig_muldiv_sim \
    && ./obj_dir/sig_muldiv_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "Testbench failed" "$LOG" && exit 1
grep -q "Testbench passed" "$LOG" || exit 1
exit 0
